/* Makefile */
TOP := tb_usb_coder_connector
LOG := sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

obj_dir/V$(TOP): verilog.f hdl/*.sv hdl/*.svh dv/*.sv
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/100ps \
		-f verilog.f --top-module usb_coder_connector

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_usb_coder_connector.sv */
`include "usb_coder_params.svh"

module tb_usb_coder_connector
	import usb_frame_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_CMDS = 40;
	localparam int FRAME_MAX = `USB_ST_BYTES + `USB_SDI_BYTES + `USB_CSI_BYTES + 2;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * FRAME_MAX * 40 + 500;

	logic                        clk = 1'b0;
	logic                        n_rst;
	logic [7:0]                  cmd;
	logic                        cmd_req;
	logic                        cmd_ack;
	logic                        cmd_err;
	logic [8*`USB_ST_BYTES-1:0]  st_bytes;
	logic [8*`USB_SDI_BYTES-1:0] sdi_bytes;
	logic [8*`USB_CSI_BYTES-1:0] csi_bytes;
	logic [7:0]                  q;
	logic                        q_req;
	logic                        q_ack;

	logic [31:0] host_lfsr = 32'hef4733ef;
	logic [31:0] coder_lfsr = 32'hef4733ef;
	logic [7:0]  exp_q[$];
	logic [7:0]  rx_q[$];
	int          exp_count = 0;
	int          rx_count = 0;
	int          checked = 0;
	int          mismatches = 0;
	int          failures = 0;
	int          cycles = 0;

	usb_coder_connector dut0 (
		.clk       (clk),
		.n_rst     (n_rst),
		.cmd       (cmd),
		.cmd_req   (cmd_req),
		.cmd_ack   (cmd_ack),
		.cmd_err   (cmd_err),
		.st_bytes  (st_bytes),
		.sdi_bytes (sdi_bytes),
		.csi_bytes (csi_bytes),
		.q         (q),
		.q_req     (q_req),
		.q_ack     (q_ack)
	);

	always #4 clk = ~clk;

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			s = lfsr_step(s);
			v = {v[30:0], s[0]};
		end
	endtask

	// Header, selected sections MSB first, then the XOR of everything before it.
	function automatic int expected_frame(input logic [7:0] opc,
		input logic [8*`USB_ST_BYTES-1:0] st, input logic [8*`USB_SDI_BYTES-1:0] sdi,
		input logic [8*`USB_CSI_BYTES-1:0] csi, output logic [7:0] fr [0:FRAME_MAX-1]);
		int n;
		int i;
		logic [7:0] cks;
		for (i = 0; i < FRAME_MAX; i++)
			fr[i] = 8'h00;
		if (opc != OP_ALL && opc != OP_ST && opc != OP_SDI && opc != OP_CSI)
			return 0;
		fr[0] = opc;
		n = 1;
		if (opc == OP_ALL || opc == OP_ST)
			for (i = `USB_ST_BYTES - 1; i >= 0; i--)
			begin
				fr[n] = st[8*i +: 8];
				n = n + 1;
			end
		if (opc == OP_ALL || opc == OP_SDI)
			for (i = `USB_SDI_BYTES - 1; i >= 0; i--)
			begin
				fr[n] = sdi[8*i +: 8];
				n = n + 1;
			end
		if (opc == OP_ALL || opc == OP_CSI)
			for (i = `USB_CSI_BYTES - 1; i >= 0; i--)
			begin
				fr[n] = csi[8*i +: 8];
				n = n + 1;
			end
		cks = `USB_CKS_SEED;
		for (i = 0; i < n; i++)
			cks = cks ^ fr[i];
		fr[n] = cks;
		return n + 1;
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
		begin
			mismatches++;
			$display("Mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
		end
	endtask

	task automatic new_sources();
		logic [31:0] hi;
		logic [31:0] lo;
		logic [31:0] r;
		take_bits(host_lfsr, 32, hi);
		take_bits(host_lfsr, 32, lo);
		st_bytes <= {hi, lo};
		take_bits(host_lfsr, 16, r);
		sdi_bytes <= r[15:0];
		take_bits(host_lfsr, 24, r);
		csi_bytes <= r[23:0];
	endtask

	// First five commands cover each opcode and one invalid code.
	task automatic pick_opcode(input int idx, output logic [7:0] opc);
		logic [31:0] r;
		if (idx < 5)
			r = idx;
		else
			take_bits(host_lfsr, 3, r);
		case (r[2:0])
			3'd0, 3'd5: opc = OP_ALL;
			3'd1, 3'd6: opc = OP_ST;
			3'd2: opc = OP_SDI;
			3'd3: opc = OP_CSI;
			default:
			begin
				take_bits(host_lfsr, 8, r);
				opc = r[7:0];
				if (opc[7:2] == 6'b101000)
					opc = opc ^ 8'h10;
			end
		endcase
	endtask

	task automatic finish_run();
		$display("Checked %0d bytes: %0d mismatches, %0d other errors",
			checked, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	// Host side of the command handshake.
	initial
	begin
		logic [31:0] r;
		logic [7:0]  opc;
		logic [7:0]  fr [0:FRAME_MAX-1];
		int          n;
		int          i;
		int          c;
		n_rst = 1'b0;
		cmd = 8'h00;
		cmd_req = 1'b0;
		st_bytes = '0;
		sdi_bytes = '0;
		csi_bytes = '0;
		repeat (10) @(posedge clk);
		n_rst <= 1'b1;
		@(posedge clk);
		new_sources();
		for (c = 0; c < NUM_CMDS; c++)
		begin
			pick_opcode(c, opc);
			@(posedge clk);
			cmd <= opc;
			@(posedge clk);
			cmd_req <= 1'b1;
			@(posedge clk);
			while (!cmd_ack)
				@(posedge clk);
			// The previous frame must be fully out before a new ack.
			check_val(rx_count, exp_count, "cmd_ack before previous frame finished");
			check_val(32'(q_ack), 0, "cmd_ack before the checksum handshake ended");
			n = expected_frame(opc, st_bytes, sdi_bytes, csi_bytes, fr);
			check_val(32'(cmd_err), 32'(n == 0), $sformatf("cmd_err for opcode %02h", opc));
			for (i = 0; i < n; i++)
				exp_q.push_back(fr[i]);
			exp_count += n;
			// Sources move on at once; the frame keeps the snapshot.
			new_sources();
			take_bits(host_lfsr, 3, r);
			repeat (r) @(posedge clk);
			cmd_req <= 1'b0;
			@(posedge clk);
			while (cmd_ack)
				@(posedge clk);
			take_bits(host_lfsr, 3, r);
			repeat (r) @(posedge clk);
		end
		while (!(rx_count == exp_count && !q_req && !q_ack))
			@(posedge clk);
		repeat (4) @(posedge clk);
		check_val(exp_q.size(), 0, "expected bytes never arrived");
		finish_run();
	end

	// Coder side of the byte handshake.
	initial
	begin
		logic [31:0] d;
		q_ack = 1'b0;
		forever
		begin
			@(posedge clk);
			if (q_req)
			begin
				take_bits(coder_lfsr, 3, d);
				repeat (d) @(posedge clk);
				rx_q.push_back(q);
				rx_count <= rx_count + 1;
				q_ack <= 1'b1;
				@(posedge clk);
				while (q_req)
					@(posedge clk);
				take_bits(coder_lfsr, 3, d);
				repeat (d) @(posedge clk);
				q_ack <= 1'b0;
			end
		end
	end

	always @(posedge clk)
	begin : compare_bytes
		logic [7:0] got;
		while (rx_q.size() > 0)
		begin
			got = rx_q.pop_front();
			if (exp_q.size() == 0)
			begin
				failures++;
				$display("Byte %02h arrived on q at %0t while no frame was expected", got, $time);
			end
			else
				check_val(32'(got), 32'(exp_q.pop_front()), $sformatf("output byte %0d", checked));
			checked++;
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
		begin
			$display("timeout: frame not completed");
			failures++;
			finish_run();
		end
	end

endmodule

/* hdl/usb_byte_link.sv */
`include "usb_coder_params.svh"

module usb_byte_link
	import usb_frame_pkg::*, usb_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] byte_data,
	input  logic       byte_last,
	input  logic       byte_valid,
	output logic       byte_taken,
	output logic       frame_done,
	output logic [7:0] q,
	output logic       q_req,
	input  logic       q_ack
);

	link_state_t state;
	logic [7:0]  cks;
	logic        last_q;
	logic        cks_out;
	logic        in_frame;
	logic        take;

	// A new byte goes out only once the coder has released q_ack.
	assign take = (state == LNK_IDLE) && byte_valid && !q_ack;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state      <= LNK_IDLE;
			byte_taken <= 1'b0;
			frame_done <= 1'b0;
			q_req      <= 1'b0;
			cks        <= `USB_CKS_SEED;
			last_q     <= 1'b0;
			cks_out    <= 1'b0;
			in_frame   <= 1'b0;
		end
		else
		begin
			byte_taken <= 1'b0;
			frame_done <= 1'b0;
			case (state)
				LNK_IDLE:
					if (take)
					begin
						byte_taken <= 1'b1;
						cks        <= cks ^ byte_data;
						last_q     <= byte_last;
						in_frame   <= 1'b1;
						state      <= LNK_REQ;
					end
				LNK_REQ:
				begin
					q_req <= 1'b1;
					if (q_req && q_ack)
					begin
						q_req <= 1'b0;
						state <= LNK_REL;
					end
				end
				LNK_REL:
					if (!q_ack)
					begin
						if (cks_out)
						begin
							frame_done <= 1'b1;
							cks        <= `USB_CKS_SEED;
							cks_out    <= 1'b0;
							in_frame   <= 1'b0;
							state      <= LNK_IDLE;
						end
						else if (last_q)
							state <= LNK_CKS;
						else
							state <= LNK_IDLE;
					end
				// Checksum byte is loaded here and sent like any other byte.
				LNK_CKS:
				begin
					cks_out <= 1'b1;
					last_q  <= 1'b0;
					state   <= LNK_REQ;
				end
				default: state <= LNK_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
			q <= byte_data;
		else if (state == LNK_CKS)
			q <= cks;
	end

	q_stable: assert property (@(posedge clk) disable iff (!n_rst)
		q_req |-> $stable(q));

	// Every frame opens with a header the decoder accepted.
	hdr_is_opcode: assert property (@(posedge clk) disable iff (!n_rst)
		take && !in_frame |-> byte_data inside {OP_ALL, OP_ST, OP_SDI, OP_CSI});

endmodule

/* hdl/usb_cmd_decode.sv */
module usb_cmd_decode
	import usb_frame_pkg::*, usb_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  logic [7:0] cmd,
	input  logic       cmd_req,
	output logic       cmd_ack,
	output logic       cmd_err,
	input  logic       frame_done,
	output logic       start,
	output frame_op_t  op
);

	dec_state_t state;
	logic       busy;
	logic       cmd_ok;
	logic       accept;

	// Only the four frame opcodes are accepted.
	always_comb
	begin
		case (cmd)
			OP_ALL, OP_ST, OP_SDI, OP_CSI: cmd_ok = 1'b1;
			default: cmd_ok = 1'b0;
		endcase
	end

	assign accept = (state == DEC_IDLE) && cmd_req;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state   <= DEC_IDLE;
			cmd_ack <= 1'b0;
			cmd_err <= 1'b0;
			start   <= 1'b0;
			busy    <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			if (frame_done)
				busy <= 1'b0;
			case (state)
				DEC_IDLE:
					if (accept)
					begin
						cmd_ack <= 1'b1;
						cmd_err <= !cmd_ok;
						start   <= cmd_ok;
						busy    <= cmd_ok;
						state   <= DEC_ACK;
					end
				DEC_ACK:
					if (!cmd_req)
					begin
						cmd_ack <= 1'b0;
						state   <= busy ? DEC_BUSY : DEC_IDLE;
					end
				// Next command waits here until the checksum has gone out.
				DEC_BUSY:
					if (!busy)
						state <= DEC_IDLE;
				default: state <= DEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept && cmd_ok)
			op <= frame_op_t'(cmd);
	end

	// The host holds cmd_req until it has seen the ack.
	ack_follows_req: assert property (@(posedge clk) disable iff (!n_rst)
		$rose(cmd_ack) |-> cmd_req && $past(cmd_req));

endmodule

/* hdl/usb_coder_connector.sv */
`include "usb_coder_params.svh"

module usb_coder_connector
	import usb_frame_pkg::*;
(
	input  logic                         clk,
	input  logic                         n_rst,
	input  logic [7:0]                   cmd,
	input  logic                         cmd_req,
	output logic                         cmd_ack,
	output logic                         cmd_err,
	input  logic [8*`USB_ST_BYTES-1:0]   st_bytes,
	input  logic [8*`USB_SDI_BYTES-1:0]  sdi_bytes,
	input  logic [8*`USB_CSI_BYTES-1:0]  csi_bytes,
	output logic [7:0]                   q,
	output logic                         q_req,
	input  logic                         q_ack
);

	logic       start;
	frame_op_t  op;
	logic [7:0] byte_data;
	logic       byte_last;
	logic       byte_valid;
	logic       byte_taken;
	logic       frame_done;

	usb_cmd_decode u_decode (
		.clk        (clk),
		.n_rst      (n_rst),
		.cmd        (cmd),
		.cmd_req    (cmd_req),
		.cmd_ack    (cmd_ack),
		.cmd_err    (cmd_err),
		.frame_done (frame_done),
		.start      (start),
		.op         (op)
	);

	usb_frame_sequencer u_sequencer (
		.clk        (clk),
		.n_rst      (n_rst),
		.start      (start),
		.op         (op),
		.st_bytes   (st_bytes),
		.sdi_bytes  (sdi_bytes),
		.csi_bytes  (csi_bytes),
		.byte_data  (byte_data),
		.byte_last  (byte_last),
		.byte_valid (byte_valid),
		.byte_taken (byte_taken)
	);

	usb_byte_link u_link (
		.clk        (clk),
		.n_rst      (n_rst),
		.byte_data  (byte_data),
		.byte_last  (byte_last),
		.byte_valid (byte_valid),
		.byte_taken (byte_taken),
		.frame_done (frame_done),
		.q          (q),
		.q_req      (q_req),
		.q_ack      (q_ack)
	);

endmodule

/* hdl/usb_coder_params.svh */
`ifndef USB_CODER_PARAMS_SVH
`define USB_CODER_PARAMS_SVH

// Data bytes per status section.
`define USB_ST_BYTES  8
`define USB_SDI_BYTES 2
`define USB_CSI_BYTES 3

// Header byte of each frame type.
`define USB_HDR_ALL 8'hA0
`define USB_HDR_ST  8'hA1
`define USB_HDR_SDI 8'hA2
`define USB_HDR_CSI 8'hA3

// XOR checksum start value.
`define USB_CKS_SEED 8'h00

`endif

/* hdl/usb_ctrl_pkg.sv */
package usb_ctrl_pkg;

	// Command intake.
	typedef enum logic [1:0]
	{
		DEC_IDLE,
		DEC_ACK,
		DEC_BUSY
	} dec_state_t;

	// Frame sequencer.
	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_HDR,
		SEQ_DATA,
		SEQ_WAIT
	} seq_state_t;

	// Output byte link.
	typedef enum logic [1:0]
	{
		LNK_IDLE,
		LNK_REQ,
		LNK_REL,
		LNK_CKS
	} link_state_t;

endpackage

/* hdl/usb_frame_pkg.sv */
`include "usb_coder_params.svh"

package usb_frame_pkg;

	// Command opcodes, sent back unchanged as the frame header.
	typedef enum logic [7:0]
	{
		OP_ALL = `USB_HDR_ALL,
		OP_ST  = `USB_HDR_ST,
		OP_SDI = `USB_HDR_SDI,
		OP_CSI = `USB_HDR_CSI
	} frame_op_t;

	// Status sections in frame order.
	// SEC_NONE marks the end of the data part.
	typedef enum logic [1:0]
	{
		SEC_ST,
		SEC_SDI,
		SEC_CSI,
		SEC_NONE
	} section_t;

endpackage

/* hdl/usb_frame_sequencer.sv */
`include "usb_coder_params.svh"

module usb_frame_sequencer
	import usb_frame_pkg::*, usb_ctrl_pkg::*;
(
	input  logic                         clk,
	input  logic                         n_rst,
	input  logic                         start,
	input  frame_op_t                    op,
	input  logic [8*`USB_ST_BYTES-1:0]   st_bytes,
	input  logic [8*`USB_SDI_BYTES-1:0]  sdi_bytes,
	input  logic [8*`USB_CSI_BYTES-1:0]  csi_bytes,
	output logic [7:0]                   byte_data,
	output logic                         byte_last,
	output logic                         byte_valid,
	input  logic                         byte_taken
);

	localparam int IDX_W = $clog2(`USB_ST_BYTES);

	seq_state_t                  state;
	section_t                    sec;
	section_t                    sec_next;
	section_t                    sec_first;
	logic [IDX_W-1:0]            idx;
	logic [IDX_W-1:0]            sec_end;
	logic [7:0]                  sec_byte;
	frame_op_t                   op_q;
	logic [8*`USB_ST_BYTES-1:0]  st_q;
	logic [8*`USB_SDI_BYTES-1:0] sdi_q;
	logic [8*`USB_CSI_BYTES-1:0] csi_q;

	// Snapshots shift left per byte, so the top byte is always next.
	always_comb
	begin
		case (sec)
			SEC_ST:
			begin
				sec_byte = st_q[8*`USB_ST_BYTES-1 -: 8];
				sec_end  = IDX_W'(`USB_ST_BYTES - 1);
			end
			SEC_SDI:
			begin
				sec_byte = sdi_q[8*`USB_SDI_BYTES-1 -: 8];
				sec_end  = IDX_W'(`USB_SDI_BYTES - 1);
			end
			SEC_CSI:
			begin
				sec_byte = csi_q[8*`USB_CSI_BYTES-1 -: 8];
				sec_end  = IDX_W'(`USB_CSI_BYTES - 1);
			end
			default:
			begin
				sec_byte = 8'h00;
				sec_end  = '0;
			end
		endcase
	end

	always_comb
	begin
		case (op_q)
			OP_ALL, OP_ST: sec_first = SEC_ST;
			OP_SDI: sec_first = SEC_SDI;
			OP_CSI: sec_first = SEC_CSI;
			default: sec_first = SEC_NONE;
		endcase
	end

	// Only a full frame runs on past its first section.
	always_comb
	begin
		sec_next = SEC_NONE;
		if (op_q == OP_ALL)
		begin
			case (sec)
				SEC_ST: sec_next = SEC_SDI;
				SEC_SDI: sec_next = SEC_CSI;
				default: sec_next = SEC_NONE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state      <= SEQ_IDLE;
			sec        <= SEC_NONE;
			idx        <= '0;
			byte_last  <= 1'b0;
			byte_valid <= 1'b0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
					if (start)
					begin
						byte_last  <= 1'b0;
						byte_valid <= 1'b1;
						state      <= SEQ_HDR;
					end
				SEQ_HDR:
					if (byte_taken)
					begin
						byte_valid <= 1'b0;
						sec        <= sec_first;
						idx        <= '0;
						state      <= SEQ_DATA;
					end
				SEQ_DATA:
				begin
					byte_last  <= (idx == sec_end) && (sec_next == SEC_NONE);
					byte_valid <= 1'b1;
					state      <= SEQ_WAIT;
				end
				SEQ_WAIT:
					if (byte_taken)
					begin
						byte_valid <= 1'b0;
						if (byte_last)
						begin
							sec   <= SEC_NONE;
							state <= SEQ_IDLE;
						end
						else if (idx == sec_end)
						begin
							sec   <= sec_next;
							idx   <= '0;
							state <= SEQ_DATA;
						end
						else
						begin
							idx   <= idx + 1'b1;
							state <= SEQ_DATA;
						end
					end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == SEQ_IDLE && start)
		begin
			op_q      <= op;
			st_q      <= st_bytes;
			sdi_q     <= sdi_bytes;
			csi_q     <= csi_bytes;
			byte_data <= op;
		end
		else if (state == SEQ_DATA)
			byte_data <= sec_byte;
		else if (state == SEQ_WAIT && byte_taken && !byte_last)
		begin
			case (sec)
				SEC_ST: st_q <= st_q << 8;
				SEC_SDI: sdi_q <= sdi_q << 8;
				SEC_CSI: csi_q <= csi_q << 8;
				default: st_q <= st_q;
			endcase
		end
	end

	hold_until_taken: assert property (@(posedge clk) disable iff (!n_rst)
		$past(byte_valid && !byte_taken) |-> $stable(byte_data) && $stable(byte_last));

endmodule

/* verilog.f */
+incdir+hdl
hdl/usb_frame_pkg.sv
hdl/usb_ctrl_pkg.sv
hdl/usb_cmd_decode.sv
hdl/usb_frame_sequencer.sv
hdl/usb_byte_link.sv
hdl/usb_coder_connector.sv
dv/tb_usb_coder_connector.sv
